/* hdl/pma_pkg.sv */
`default_nettype none

package pma_pkg;

  ////////////////////////////////////////////////////////////
  // Address types
  ////////////////////////////////////////////////////////////

  // Byte address as seen on the request side
  typedef logic [31:0] addr_t;

  // Word address, byte address shifted right by two
  typedef logic [31:0] word_addr_t;

  // Access size of a request
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } size_e;

  // Splitter FSM states
  typedef enum logic {
    SPLIT_IDLE   = 1'b0,
    SPLIT_SECOND = 1'b1
  } split_state_e;

  ////////////////////////////////////////////////////////////
  // Region table
  ////////////////////////////////////////////////////////////

  // One region record, bounds in words, high bound exclusive
  typedef struct packed {
    word_addr_t word_addr_low;
    word_addr_t word_addr_high;
    logic       main;
    logic       bufferable;
    logic       cacheable;
    logic       atomic;
  } pma_cfg_t;

  localparam int PMA_NUM_REGIONS = 3;

  // Scanned from index 0 upwards, so a later entry overrides an earlier one
  localparam pma_cfg_t PMA_CFG [PMA_NUM_REGIONS] = '{
    // Main memory, bytes 0x0000_0000 to 0x0001_0000
    '{word_addr_low: 32'h0000_0000, word_addr_high: 32'h0000_4000,
      main: 1'b1, bufferable: 1'b0, cacheable: 1'b1, atomic: 1'b1},
    // Peripheral I/O, bytes 0x1000_0000 to 0x1000_1000
    '{word_addr_low: 32'h0400_0000, word_addr_high: 32'h0400_0400,
      main: 1'b0, bufferable: 1'b1, cacheable: 1'b0, atomic: 1'b0},
    // Uncached window inside entry 0, bytes 0x0000_8000 to 0x0000_9000
    '{word_addr_low: 32'h0000_2000, word_addr_high: 32'h0000_2400,
      main: 1'b1, bufferable: 1'b0, cacheable: 1'b0, atomic: 1'b0}
  };

  // No region hit, treated as plain I/O
  localparam pma_cfg_t PMA_R_DEFAULT = '{
    word_addr_low: '0, word_addr_high: '0,
    main: 1'b0, bufferable: 1'b0, cacheable: 1'b0, atomic: 1'b0};

  // Debug module seen from debug mode, bounds unused
  localparam pma_cfg_t PMA_DBG = '{
    word_addr_low: '0, word_addr_high: '0,
    main: 1'b1, bufferable: 1'b0, cacheable: 1'b0, atomic: 1'b0};

  // Debug module byte range, end exclusive
  localparam addr_t DM_REGION_START = 32'h1A11_0800;
  localparam addr_t DM_REGION_END   = 32'h1A11_1000;

endpackage

`default_nettype wire

/* hdl/pma_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module pma_checker #(
  parameter bit A_EXT = 1'b1
) (
  input  pma_pkg::addr_t trans_addr_i,
  // Beat from debug mode inside the debug module range
  input  logic           trans_debug_region_i,
  input  logic           trans_pushpop_i,
  input  logic           instr_fetch_access_i,
  input  logic           atomic_access_i,
  // Beat belongs to a split request
  input  logic           misaligned_access_i,
  input  logic           load_access_i,
  output logic           pma_err_o,
  output logic           pma_misaligned_atomic_o,
  output logic           pma_bufferable_o,
  output logic           pma_cacheable_o
);

  import pma_pkg::*;

  word_addr_t word_addr;
  pma_cfg_t   pma_cfg;
  logic       cfg_atomic;
  logic       atomic_access;

  // Table bounds are in words
  assign word_addr = {2'b00, trans_addr_i[31:2]};

  ////////////////////////////////////////////////////////////
  // Region lookup
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Fall back to I/O when nothing matches
    pma_cfg = PMA_R_DEFAULT;

    // Ascending scan, highest matching index ends up in pma_cfg
    for (int i = 0; i < PMA_NUM_REGIONS; i++) begin
      if ((word_addr >= PMA_CFG[i].word_addr_low) &&
          (word_addr <  PMA_CFG[i].word_addr_high)) begin
        pma_cfg = PMA_CFG[i];
      end
    end

    // Debug module attributes beat any table entry
    if (trans_debug_region_i) begin
      pma_cfg = PMA_DBG;
    end
  end

  ////////////////////////////////////////////////////////////
  // Atomic extension
  ////////////////////////////////////////////////////////////

  if (A_EXT) begin : g_atomic
    assign cfg_atomic    = pma_cfg.atomic;
    assign atomic_access = atomic_access_i;
    // Atomic that straddles a word, never issued
    assign pma_misaligned_atomic_o = atomic_access_i && misaligned_access_i;
  end else begin : g_no_atomic
    // Without the extension no access counts as atomic
    assign cfg_atomic    = 1'b0;
    assign atomic_access = 1'b0;
    assign pma_misaligned_atomic_o = 1'b0;
  end

  ////////////////////////////////////////////////////////////
  // Error decision
  ////////////////////////////////////////////////////////////

  always_comb begin
    pma_err_o = 1'b0;

    // Atomic to a region without atomic support
    if (atomic_access && !cfg_atomic) begin
      pma_err_o = 1'b1;
    end

    // Code only runs from main memory
    if (instr_fetch_access_i && !pma_cfg.main) begin
      pma_err_o = 1'b1;
    end

    // I/O cannot take split accesses
    if (misaligned_access_i && !pma_cfg.main) begin
      pma_err_o = 1'b1;
    end

    // Stack push/pop only to main memory
    if (trans_pushpop_i && !pma_cfg.main) begin
      pma_err_o = 1'b1;
    end
  end

  // Fetches, atomics and loads are never bufferable
  assign pma_bufferable_o = pma_cfg.bufferable && !instr_fetch_access_i &&
                            !atomic_access && !load_access_i;

  // Cacheable passes straight from the region
  assign pma_cacheable_o  = pma_cfg.cacheable;

endmodule

`default_nettype wire

/* hdl/lsu_split.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_split (
  input  logic           clk_i,
  input  logic           rst_n_i,
  // Request side, req_i is a single-cycle strobe
  input  logic           req_i,
  input  pma_pkg::addr_t req_addr_i,
  input  pma_pkg::size_e req_size_i,
  input  logic           req_we_i,
  input  logic           req_atomic_i,
  input  logic           req_fetch_i,
  input  logic           req_pushpop_i,
  input  logic           dbg_mode_i,
  output logic           busy_o,
  // Word-aligned beats towards the MPU
  output logic           beat_valid_o,
  output pma_pkg::addr_t beat_addr_o,
  output logic           beat_misaligned_o,
  output logic           beat_we_o,
  output logic           beat_atomic_o,
  output logic           beat_fetch_o,
  output logic           beat_pushpop_o,
  output logic           beat_dbg_o
);

  import pma_pkg::*;

  split_state_e state;
  logic         req_accept;
  logic         req_misaligned;

  // Only taken while idle
  assign req_accept = req_i && (state == SPLIT_IDLE);

  // Second beat still pending
  assign busy_o = (state == SPLIT_SECOND);

  // Does the access cross into the next word
  always_comb begin
    case (req_size_i)
      SIZE_HALF: req_misaligned = (req_addr_i[1:0] == 2'b11);
      SIZE_WORD: req_misaligned = (req_addr_i[1:0] != 2'b00);
      default:   req_misaligned = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Splitter FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state        <= SPLIT_IDLE;
      beat_valid_o <= 1'b0;
    end else begin
      beat_valid_o <= 1'b0;
      case (state)
        SPLIT_IDLE: begin
          if (req_accept) begin
            beat_valid_o <= 1'b1;
            // Crossing request needs a second beat
            if (req_misaligned) begin
              state <= SPLIT_SECOND;
            end
          end
        end
        SPLIT_SECOND: begin
          beat_valid_o <= 1'b1;
          state        <= SPLIT_IDLE;
        end
        default: state <= SPLIT_IDLE;
      endcase
    end
  end

  // Beat payload
  always_ff @(posedge clk_i) begin
    if (req_accept) begin
      beat_addr_o       <= {req_addr_i[31:2], 2'b00};
      beat_misaligned_o <= req_misaligned;
      beat_we_o         <= req_we_i;
      beat_atomic_o     <= req_atomic_i;
      beat_fetch_o      <= req_fetch_i;
      beat_pushpop_o    <= req_pushpop_i;
      // Mode as seen with the request
      beat_dbg_o        <= dbg_mode_i;
    end else if (state == SPLIT_SECOND) begin
      // Next word, kind fields held
      beat_addr_o <= beat_addr_o + 32'd4;
    end
  end

  // Requester must respect busy_o
  a_no_req_while_busy : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    req_i |-> !busy_o
  );

  // Atomics are word sized only
  a_atomic_word : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (req_i && req_atomic_i) |-> (req_size_i == SIZE_WORD)
  );

endmodule

`default_nettype wire

/* hdl/lsu_mpu.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_mpu #(
  parameter bit A_EXT = 1'b1
) (
  input  logic           clk_i,
  input  logic           rst_n_i,
  // Beat from the splitter
  input  logic           beat_valid_i,
  input  pma_pkg::addr_t beat_addr_i,
  input  logic           beat_misaligned_i,
  input  logic           beat_we_i,
  input  logic           beat_atomic_i,
  input  logic           beat_fetch_i,
  input  logic           beat_pushpop_i,
  input  logic           beat_dbg_i,
  // Bus strobe with attributes
  output logic           bus_req_o,
  output pma_pkg::addr_t bus_addr_o,
  output logic           bus_we_o,
  output logic           bus_bufferable_o,
  output logic           bus_cacheable_o,
  // Error pulse in place of the strobe
  output logic           err_o,
  output pma_pkg::addr_t err_addr_o,
  output logic           misaligned_atomic_o
);

  import pma_pkg::*;

  logic debug_region;
  logic pma_err;
  logic pma_misaligned_atomic;
  logic pma_bufferable;
  logic pma_cacheable;
  logic beat_fail;

  // Debug mode access to the debug module
  assign debug_region = beat_dbg_i &&
                        (beat_addr_i >= DM_REGION_START) &&
                        (beat_addr_i <  DM_REGION_END);

  pma_checker #(
    .A_EXT (A_EXT)
  ) u_pma_checker (
    .trans_addr_i            (beat_addr_i),
    .trans_debug_region_i    (debug_region),
    .trans_pushpop_i         (beat_pushpop_i),
    .instr_fetch_access_i    (beat_fetch_i),
    .atomic_access_i         (beat_atomic_i),
    .misaligned_access_i     (beat_misaligned_i),
    .load_access_i           (!beat_we_i),
    .pma_err_o               (pma_err),
    .pma_misaligned_atomic_o (pma_misaligned_atomic),
    .pma_bufferable_o        (pma_bufferable),
    .pma_cacheable_o         (pma_cacheable)
  );

  // Misaligned atomic is dropped even in an atomic region
  assign beat_fail = pma_err || pma_misaligned_atomic;

  ////////////////////////////////////////////////////////////
  // Outcome register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bus_req_o           <= 1'b0;
      err_o               <= 1'b0;
      misaligned_atomic_o <= 1'b0;
    end else begin
      bus_req_o           <= beat_valid_i && !beat_fail;
      err_o               <= beat_valid_i && beat_fail;
      misaligned_atomic_o <= beat_valid_i && pma_misaligned_atomic;
    end
  end

  // Payload follows the beat
  always_ff @(posedge clk_i) begin
    if (beat_valid_i) begin
      bus_addr_o       <= beat_addr_i;
      bus_we_o         <= beat_we_i;
      bus_bufferable_o <= pma_bufferable;
      bus_cacheable_o  <= pma_cacheable;
      err_addr_o       <= beat_addr_i;
    end
  end

  // Strobe and error are exclusive
  a_req_err_excl : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(bus_req_o && err_o)
  );

endmodule

`default_nettype wire

/* hdl/lsu_pma_top.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_pma_top #(
  parameter bit A_EXT = 1'b1
) (
  input  logic           clk_i,
  input  logic           rst_n_i,
  // Request side
  input  logic           req_i,
  input  pma_pkg::addr_t req_addr_i,
  input  pma_pkg::size_e req_size_i,
  input  logic           req_we_i,
  input  logic           req_atomic_i,
  input  logic           req_fetch_i,
  input  logic           req_pushpop_i,
  input  logic           dbg_mode_i,
  output logic           busy_o,
  // Bus side
  output logic           bus_req_o,
  output pma_pkg::addr_t bus_addr_o,
  output logic           bus_we_o,
  output logic           bus_bufferable_o,
  output logic           bus_cacheable_o,
  output logic           err_o,
  output pma_pkg::addr_t err_addr_o,
  output logic           misaligned_atomic_o
);

  import pma_pkg::*;

  ////////////////////////////////////////////////////////////
  // Beat wires, splitter to MPU
  ////////////////////////////////////////////////////////////

  logic  beat_valid;
  addr_t beat_addr;
  logic  beat_misaligned;
  logic  beat_we;
  logic  beat_atomic;
  logic  beat_fetch;
  logic  beat_pushpop;
  logic  beat_dbg;

  lsu_split u_lsu_split (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .req_i             (req_i),
    .req_addr_i        (req_addr_i),
    .req_size_i        (req_size_i),
    .req_we_i          (req_we_i),
    .req_atomic_i      (req_atomic_i),
    .req_fetch_i       (req_fetch_i),
    .req_pushpop_i     (req_pushpop_i),
    .dbg_mode_i        (dbg_mode_i),
    .busy_o            (busy_o),
    .beat_valid_o      (beat_valid),
    .beat_addr_o       (beat_addr),
    .beat_misaligned_o (beat_misaligned),
    .beat_we_o         (beat_we),
    .beat_atomic_o     (beat_atomic),
    .beat_fetch_o      (beat_fetch),
    .beat_pushpop_o    (beat_pushpop),
    .beat_dbg_o        (beat_dbg)
  );

  lsu_mpu #(
    .A_EXT (A_EXT)
  ) u_lsu_mpu (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .beat_valid_i        (beat_valid),
    .beat_addr_i         (beat_addr),
    .beat_misaligned_i   (beat_misaligned),
    .beat_we_i           (beat_we),
    .beat_atomic_i       (beat_atomic),
    .beat_fetch_i        (beat_fetch),
    .beat_pushpop_i      (beat_pushpop),
    .beat_dbg_i          (beat_dbg),
    .bus_req_o           (bus_req_o),
    .bus_addr_o          (bus_addr_o),
    .bus_we_o            (bus_we_o),
    .bus_bufferable_o    (bus_bufferable_o),
    .bus_cacheable_o     (bus_cacheable_o),
    .err_o               (err_o),
    .err_addr_o          (err_addr_o),
    .misaligned_atomic_o (misaligned_atomic_o)
  );

endmodule

`default_nettype wire

/* bench/pma_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

module pma_monitor (
  input  logic           clk_i,
  input  logic           rst_n_i,
  // Expected outcome valid with the request strobe
  input  logic           exp_valid_i,
  input  int             exp_test_i,
  input  pma_pkg::addr_t exp_addr_i,
  input  logic           exp_we_i,
  input  logic [3:0]     exp_beat0_i,
  input  logic [3:0]     exp_beat1_i,
  // DUT request side
  input  logic           busy_i,
  // DUT bus side
  input  logic           bus_req_i,
  input  pma_pkg::addr_t bus_addr_i,
  input  logic           bus_we_i,
  input  logic           bus_bufferable_i,
  input  logic           bus_cacheable_i,
  input  logic           err_i,
  input  pma_pkg::addr_t err_addr_i,
  input  logic           misaligned_atomic_i,
  // Running counts for the testbench top
  output int             pending_o,
  output int             mismatches_o,
  output int             unexpected_o,
  output int             tests_passed_o,
  output int             tests_failed_o
);

  import pma_pkg::*;

  // Outcome codes of the testdata file where bit 2 marks a bus strobe
  localparam logic [3:0] OUT_NONE       = 4'h0;
  localparam logic [3:0] OUT_MIS_ATOMIC = 4'h2;

  // Expected beats in issue order
  int         q_test[$];
  int         q_beat[$];
  addr_t      q_addr[$];
  logic       q_we[$];
  logic [3:0] q_code[$];
  logic       q_last[$];
  int         test_errs;

  // Split request taken on the previous edge
  logic       split_taken;
  int         split_test;

  task automatic report_mismatch(input int test, input int beat, input string msg);
    $display("FAIL %0t: test %0d beat %0d %s", $time, test, beat, msg);
    mismatches_o++;
    test_errs++;
  endtask

  ////////////////////////////////////////////////////////////
  // One outcome pulse against one expected beat
  ////////////////////////////////////////////////////////////

  task automatic check_outcome(input int test, input int beat, input addr_t addr,
                               input logic we, input logic [3:0] code);
    if (code[2]) begin
      // Bus strobe with attributes in the low code bits
      if (!bus_req_i || err_i) begin
        report_mismatch(test, beat, $sformatf("expected bus strobe, got bus_req %b err %b",
                                              bus_req_i, err_i));
      end else begin
        if (bus_addr_i !== addr)
          report_mismatch(test, beat, $sformatf("bus_addr %h, expected %h", bus_addr_i, addr));
        if (bus_we_i !== we)
          report_mismatch(test, beat, $sformatf("bus_we %b, expected %b", bus_we_i, we));
        if (bus_bufferable_i !== code[1])
          report_mismatch(test, beat, $sformatf("bufferable %b, expected %b",
                                                bus_bufferable_i, code[1]));
        if (bus_cacheable_i !== code[0])
          report_mismatch(test, beat, $sformatf("cacheable %b, expected %b",
                                                bus_cacheable_i, code[0]));
        if (misaligned_atomic_i)
          report_mismatch(test, beat, "misaligned_atomic set on a bus strobe");
      end
    end else begin
      // Dropped beat gives an error pulse instead
      if (!err_i || bus_req_i) begin
        report_mismatch(test, beat, $sformatf("expected error, got bus_req %b err %b",
                                              bus_req_i, err_i));
      end else begin
        if (err_addr_i !== addr)
          report_mismatch(test, beat, $sformatf("err_addr %h, expected %h", err_addr_i, addr));
        if (misaligned_atomic_i !== (code == OUT_MIS_ATOMIC))
          report_mismatch(test, beat, $sformatf("misaligned_atomic %b, expected %b",
                                                misaligned_atomic_i, code == OUT_MIS_ATOMIC));
      end
    end
  endtask

  // Result line once the last beat of a test is in
  task automatic report_test(input int test);
    if (test_errs == 0) begin
      tests_passed_o++;
      $display("PASS test %0d", test);
    end else begin
      tests_failed_o++;
      $display("Test %0d done, %0d mismatches", test, test_errs);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Outputs are flops so the pre-edge value is stable
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      q_test.delete();
      q_beat.delete();
      q_addr.delete();
      q_we.delete();
      q_code.delete();
      q_last.delete();
      test_errs      = 0;
      split_taken    = 1'b0;
      split_test     = 0;
      pending_o      = 0;
      mismatches_o   = 0;
      unexpected_o   = 0;
      tests_passed_o = 0;
      tests_failed_o = 0;
    end else begin
      // Busy only in the cycle after a split request
      if (busy_i !== split_taken) begin
        mismatches_o++;
        $display("FAIL %0t: busy %b near test %0d, expected %b",
                 $time, busy_i, split_test, split_taken);
      end
      if (bus_req_i || err_i) begin
        if (q_code.size() == 0) begin
          unexpected_o++;
          $display("Outcome pulse at %0t with no request waiting for it", $time);
        end else begin
          // First beat opens a fresh test
          if (q_beat[0] == 0) test_errs = 0;
          check_outcome(q_test[0], q_beat[0], q_addr[0], q_we[0], q_code[0]);
          if (q_last[0]) report_test(q_test[0]);
          void'(q_test.pop_front());
          void'(q_beat.pop_front());
          void'(q_addr.pop_front());
          void'(q_we.pop_front());
          void'(q_code.pop_front());
          void'(q_last.pop_front());
        end
      end
      if (exp_valid_i) begin
        // First beat at the word-aligned address
        q_test.push_back(exp_test_i);
        q_beat.push_back(0);
        q_addr.push_back({exp_addr_i[31:2], 2'b00});
        q_we.push_back(exp_we_i);
        q_code.push_back(exp_beat0_i);
        q_last.push_back(exp_beat1_i == OUT_NONE);
        split_test = exp_test_i;
        // Split request has the next word following
        if (exp_beat1_i != OUT_NONE) begin
          q_test.push_back(exp_test_i);
          q_beat.push_back(1);
          q_addr.push_back({exp_addr_i[31:2], 2'b00} + 32'd4);
          q_we.push_back(exp_we_i);
          q_code.push_back(exp_beat1_i);
          q_last.push_back(1'b1);
        end
      end
      split_taken = exp_valid_i && (exp_beat1_i != OUT_NONE);
      pending_o = q_code.size();
    end
  end

endmodule

`default_nettype wire

/* bench/tb_lsu_pma.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_lsu_pma;

  import pma_pkg::*;

  // Region table as seen from the bus
  // Entry 0 is main memory from 0x0000_0000 up to 0x0001_0000, cacheable and atomic
  // Entry 1 is I/O from 0x1000_0000 up to 0x1000_1000, bufferable only
  // Entry 2 is main memory from 0x0000_8000 up to 0x0000_9000, no cache, no atomic
  // Entry 2 wins over entry 0 where both match
  // Any other address is I/O with no attributes
  // Debug mode inside 0x1A11_0800 up to 0x1A11_1000 sees main memory, no buffer, no cache

  logic       clk;
  logic       rst_n;
  logic       req;
  addr_t      req_addr;
  size_e      req_size;
  logic       req_we;
  logic       req_atomic;
  logic       req_fetch;
  logic       req_pushpop;
  logic       dbg_mode;
  logic       busy;
  logic       bus_req;
  addr_t      bus_addr;
  logic       bus_we;
  logic       bus_bufferable;
  logic       bus_cacheable;
  logic       err;
  addr_t      err_addr;
  logic       misaligned_atomic;

  // Expected outcome handed to the monitor
  logic       exp_valid;
  int         exp_test;
  logic [3:0] exp_beat0;
  logic [3:0] exp_beat1;

  // Monitor counts
  int         pending;
  int         mismatches;
  int         unexpected;
  int         tests_passed;
  int         tests_failed;

  // Vectors from the testdata file
  int         v_test[$];
  addr_t      v_addr[$];
  logic [1:0] v_size[$];
  logic       v_we[$];
  logic       v_atomic[$];
  logic       v_fetch[$];
  logic       v_pushpop[$];
  logic       v_dbg[$];
  logic [3:0] v_beat0[$];
  logic [3:0] v_beat1[$];

  int         bad_lines = 0;
  logic       open_failed = 1'b0;
  int         cycle_count = 0;
  int         cycle_limit = 1000;

  lsu_pma_top #(
    .A_EXT (1'b1)
  ) DUT (
    .clk_i               (clk),
    .rst_n_i             (rst_n),
    .req_i               (req),
    .req_addr_i          (req_addr),
    .req_size_i          (req_size),
    .req_we_i            (req_we),
    .req_atomic_i        (req_atomic),
    .req_fetch_i         (req_fetch),
    .req_pushpop_i       (req_pushpop),
    .dbg_mode_i          (dbg_mode),
    .busy_o              (busy),
    .bus_req_o           (bus_req),
    .bus_addr_o          (bus_addr),
    .bus_we_o            (bus_we),
    .bus_bufferable_o    (bus_bufferable),
    .bus_cacheable_o     (bus_cacheable),
    .err_o               (err),
    .err_addr_o          (err_addr),
    .misaligned_atomic_o (misaligned_atomic)
  );

  pma_monitor u_pma_monitor (
    .clk_i               (clk),
    .rst_n_i             (rst_n),
    .exp_valid_i         (exp_valid),
    .exp_test_i          (exp_test),
    .exp_addr_i          (req_addr),
    .exp_we_i            (req_we),
    .exp_beat0_i         (exp_beat0),
    .exp_beat1_i         (exp_beat1),
    .busy_i              (busy),
    .bus_req_i           (bus_req),
    .bus_addr_i          (bus_addr),
    .bus_we_i            (bus_we),
    .bus_bufferable_i    (bus_bufferable),
    .bus_cacheable_i     (bus_cacheable),
    .err_i               (err),
    .err_addr_i          (err_addr),
    .misaligned_atomic_i (misaligned_atomic),
    .pending_o           (pending),
    .mismatches_o        (mismatches),
    .unexpected_o        (unexpected),
    .tests_passed_o      (tests_passed),
    .tests_failed_o      (tests_failed)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Watchdog limit is set once the vectors are known
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, %0d expected outcomes never arrived",
               cycle_count, pending);
      $display("Finished with errors");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Vector file and request driver
  ////////////////////////////////////////////////////////////

  task automatic load_vectors();
    int         fd;
    int         n;
    string      line;
    int         t;
    addr_t      a;
    logic [1:0] s;
    logic       we;
    logic       at;
    logic       fe;
    logic       pp;
    logic       db;
    logic [3:0] b0;
    logic [3:0] b1;
    fd = $fopen("bench/pma_testdata.txt", "r");
    if (fd == 0) begin
      open_failed = 1'b1;
      $display("Cannot open bench/pma_testdata.txt for reading");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        n = $sscanf(line, "%d %h %d %d %d %d %d %d %h %h",
                    t, a, s, we, at, fe, pp, db, b0, b1);
        if (n == 10) begin
          v_test.push_back(t);
          v_addr.push_back(a);
          v_size.push_back(s);
          v_we.push_back(we);
          v_atomic.push_back(at);
          v_fetch.push_back(fe);
          v_pushpop.push_back(pp);
          v_dbg.push_back(db);
          v_beat0.push_back(b0);
          v_beat1.push_back(b1);
        end else if (line.len() > 1 && line[0] != "#") begin
          // Neither comment nor blank, yet not a vector
          bad_lines++;
          $display("Testdata line not understood: %s", line);
        end
      end
      $fclose(fd);
    end
  endtask

  // One request strobe, then hold off while the splitter is busy
  task automatic issue_request(input int i);
    req_addr    = v_addr[i];
    req_size    = size_e'(v_size[i]);
    req_we      = v_we[i];
    req_atomic  = v_atomic[i];
    req_fetch   = v_fetch[i];
    req_pushpop = v_pushpop[i];
    dbg_mode    = v_dbg[i];
    exp_test    = v_test[i];
    exp_beat0   = v_beat0[i];
    exp_beat1   = v_beat1[i];
    req         = 1'b1;
    exp_valid   = 1'b1;
    @(negedge clk);
    req       = 1'b0;
    exp_valid = 1'b0;
    // Second beat of a split request
    while (busy) @(negedge clk);
  endtask

  initial begin
    req         = 1'b0;
    req_addr    = '0;
    req_size    = SIZE_WORD;
    req_we      = 1'b0;
    req_atomic  = 1'b0;
    req_fetch   = 1'b0;
    req_pushpop = 1'b0;
    dbg_mode    = 1'b0;
    exp_valid   = 1'b0;
    exp_test    = 0;
    exp_beat0   = '0;
    exp_beat1   = '0;
    rst_n       = 1'b0;
    load_vectors();
    cycle_limit = v_test.size() * 6 + 20;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    foreach (v_test[i]) issue_request(i);
    // Outcomes trail the requests by two cycles
    while (pending != 0) @(negedge clk);
    // Room for a stray pulse to show up
    repeat (2) @(negedge clk);
    $display("Tests %0d passed, %0d failed, %0d mismatches, %0d unexpected, %0d bad lines",
             tests_passed, tests_failed, mismatches, unexpected, bad_lines);
    if (open_failed || bad_lines != 0 || mismatches != 0 || unexpected != 0 ||
        tests_failed != 0 || v_test.size() == 0 || tests_passed != v_test.size()) begin
      $display("Finished with errors");
    end else begin
      $display("Finished with no errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/pma_testdata.txt */
# test addr(hex) size(0 byte 1 half 2 word) we atomic fetch pushpop dbg beat0 beat1
# beat code: 0 none, 1 error, 2 misaligned atomic error, 4 + 2*bufferable + cacheable bus
1  00000100 2 0 0 0 0 0 5 0
2  10000010 2 1 0 0 0 0 6 0
3  00000203 0 1 0 0 0 0 5 0
4  00008010 2 0 0 0 0 0 4 0
5  00008020 2 1 0 0 0 0 4 0
6  20000000 2 0 0 0 0 0 4 0
7  20000000 2 0 0 1 0 0 1 0
8  00000200 2 0 0 1 0 0 5 0
9  00000102 2 0 0 0 0 0 5 5
10 10000102 2 0 0 0 0 0 1 1
11 000001ff 1 1 0 0 0 0 5 5
12 00000101 1 0 0 0 0 0 5 0
13 00007ffe 2 1 0 0 0 0 5 4
14 00000300 2 1 1 0 0 0 5 0
15 10000020 2 1 1 0 0 0 1 0
16 00000302 2 1 1 0 0 0 2 2
17 00008100 2 0 1 0 0 0 1 0
18 10000040 2 1 0 0 1 0 1 0
19 00000400 2 1 0 0 1 0 5 0
20 1a110900 2 0 0 1 0 1 4 0
21 1a110900 2 0 0 1 0 0 1 0
22 00000500 2 0 0 1 0 1 5 0
23 1a111000 2 0 0 1 0 1 1 0
24 1a110800 2 1 0 0 0 1 4 0
25 10000003 1 1 0 0 0 0 1 1
26 10000005 0 1 0 0 0 0 6 0
27 0000fffe 2 1 0 0 0 0 5 1

/* src.f */
hdl/pma_pkg.sv
hdl/pma_checker.sv
hdl/lsu_split.sv
hdl/lsu_mpu.sv
hdl/lsu_pma_top.sv
bench/pma_monitor.sv
bench/tb_lsu_pma.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f src.f \
  --top-module tb_lsu_pma \
  -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
